/* rtl/icache_pkg.sv */
// cache geometry, bus structs and controller state type, compiled before all cache RTL
`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_WIDTH   = 16;
  localparam int unsigned NUM_WAYS     = 4;
  localparam int unsigned NUM_SETS     = 16;
  localparam int unsigned LINE_WORDS   = 4;
  localparam int unsigned WORD_WIDTH   = 32;
  localparam int unsigned LINE_WIDTH   = LINE_WORDS * WORD_WIDTH;
  localparam int unsigned OFFSET_WIDTH = 2;
  localparam int unsigned INDEX_WIDTH  = 4;
  // two byte bits below the word offset
  localparam int unsigned TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;
  localparam int unsigned WAY_WIDTH    = 2;
  // top address bit selects the uncached region
  localparam int unsigned NC_ADDR_BIT  = 15;
  localparam logic [7:0]  LFSR_SEED    = 8'hA5;

  typedef logic [WORD_WIDTH-1:0]  word_t;
  typedef logic [LINE_WIDTH-1:0]  line_t;
  typedef logic [TAG_WIDTH-1:0]   tag_t;
  typedef logic [INDEX_WIDTH-1:0] index_t;
  typedef logic [WAY_WIDTH-1:0]   way_t;

  //////////////////////////////////////////////////
  // fetch port and decoded address
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                  req;
    logic [ADDR_WIDTH-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic                  valid;
    word_t                 word;
    logic [ADDR_WIDTH-1:0] addr;
  } fetch_rsp_t;

  typedef struct packed {
    tag_t                    tag;
    index_t                  index;
    logic [OFFSET_WIDTH-1:0] offset;
    logic                    nc;
  } line_addr_t;

  //////////////////////////////////////////////////
  // wishbone classic, one line per beat
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [ADDR_WIDTH-1:0] adr;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    line_t dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    LOOKUP,
    REFILL
  } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/icache_decode.sv */
// fetch address decode stage, holds the accepted request for the lookup and refill stages
`timescale 1ns/1ns
`default_nettype none

module icache_decode (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  icache_pkg::fetch_req_t fetch_req_i,
  input  logic                   fetch_accept_i,
  input  logic                   cache_en_i,
  output icache_pkg::index_t     lookup_idx_o,
  output icache_pkg::line_addr_t dec_o
);

  import icache_pkg::*;

  line_addr_t dec_d;
  line_addr_t dec_q;

  // set index goes straight to the arrays, read at the accept edge
  assign lookup_idx_o = fetch_req_i.addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];

  always_comb begin
    dec_d.tag    = fetch_req_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    dec_d.index  = lookup_idx_o;
    // byte bits are dropped, fetches are word aligned
    dec_d.offset = fetch_req_i.addr[2 +: OFFSET_WIDTH];
    // uncached region, or whole cache turned off
    dec_d.nc     = fetch_req_i.addr[NC_ADDR_BIT] | ~cache_en_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_q <= '0;
    end else if (fetch_accept_i) begin
      dec_q <= dec_d;
    end
  end

  assign dec_o = dec_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // word select in the data store relies on a steady offset until the next accept
  offset_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !fetch_accept_i |=> $stable(dec_o.offset))
    else $error("decoded offset changed without an accepted fetch");

endmodule

`default_nettype wire

/* rtl/icache_ctrl.sv */
// cache controller FSM, drives flush sweep, array enables, fetch handshake and the wishbone master
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  icache_pkg::fetch_req_t fetch_req_i,
  input  logic                   en_i,
  input  logic                   flush_i,
  input  icache_pkg::line_addr_t dec_i,
  input  logic                   hit_i,
  input  icache_pkg::wb_rsp_t    wb_rsp_i,
  output icache_pkg::wb_req_t    wb_req_o,
  output logic                   fetch_ready_o,
  output logic                   fetch_accept_o,
  output logic                   rd_en_o,
  output logic                   fill_en_o,
  output logic                   clr_en_o,
  output logic                   valid_o,
  output logic                   use_fill_o,
  output icache_pkg::index_t     clr_idx_o,
  output logic                   cache_en_o
);

  import icache_pkg::*;

  ctrl_state_e state_d;
  ctrl_state_e state_q;
  index_t flush_cnt_q;
  logic flush_done;
  logic flush_pend_q;
  logic cache_en_q;
  logic cyc_d;
  logic cyc_q;
  logic [ADDR_WIDTH-1:0] adr_q;
  logic ready;
  logic hit_ok;

  // turning the cache off is immediate, turning it on waits for a flush
  assign cache_en_o = cache_en_q & en_i;

  assign flush_done = (state_q == FLUSH) && (flush_cnt_q == index_t'(NUM_SETS - 1));
  assign clr_en_o   = (state_q == FLUSH);
  assign clr_idx_o  = flush_cnt_q;

  // uncached accesses reuse the miss path
  assign hit_ok = hit_i & ~dec_i.nc;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    ready      = 1'b0;
    valid_o    = 1'b0;
    fill_en_o  = 1'b0;
    use_fill_o = 1'b0;
    cyc_d      = cyc_q;

    unique case (state_q)
      // one set cleared per cycle
      FLUSH: begin
        if (flush_done) begin
          state_d = IDLE;
        end
      end
      // pending flush or enable goes first
      IDLE: begin
        if (flush_pend_q || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          ready = 1'b1;
          if (fetch_req_i.req) begin
            state_d = LOOKUP;
          end
        end
      end
      // tags compared here, hit returns and may take the next fetch
      LOOKUP: begin
        if (hit_ok) begin
          valid_o = 1'b1;
          ready   = ~flush_pend_q;
          state_d = (ready && fetch_req_i.req) ? LOOKUP : IDLE;
        end else begin
          cyc_d   = 1'b1;
          state_d = REFILL;
        end
      end
      // word comes from the bus line, written back only if cacheable
      REFILL: begin
        use_fill_o = 1'b1;
        if (wb_rsp_i.ack) begin
          valid_o   = 1'b1;
          fill_en_o = ~dec_i.nc;
          cyc_d     = 1'b0;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  assign fetch_ready_o  = ready;
  assign fetch_accept_o = ready & fetch_req_i.req;
  // no array read needed while the cache is off
  assign rd_en_o        = fetch_accept_o & cache_en_o;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FLUSH;
      flush_cnt_q  <= '0;
      flush_pend_q <= 1'b0;
      cache_en_q   <= 1'b0;
      cyc_q        <= 1'b0;
    end else begin
      state_q      <= state_d;
      flush_cnt_q  <= (state_q == FLUSH) ? flush_cnt_q + 1'b1 : '0;
      // a flush in progress covers any earlier request
      flush_pend_q <= (flush_pend_q & (state_q != FLUSH)) | flush_i;
      cache_en_q   <= flush_done ? en_i : cache_en_o;
      cyc_q        <= cyc_d;
    end
  end

  // line address latched when the read starts
  always_ff @(posedge clk_i) begin
    if (state_q == LOOKUP && !hit_ok) begin
      adr_q <= {dec_i.tag, dec_i.index, {(OFFSET_WIDTH + 2){1'b0}}};
    end
  end

  assign wb_req_o.cyc = cyc_q;
  assign wb_req_o.stb = cyc_q;
  assign wb_req_o.we  = 1'b0;
  assign wb_req_o.adr = adr_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, LOOKUP, REFILL})
    else $error("controller in an illegal state");

  stb_in_cyc: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_req_o.stb |-> wb_req_o.cyc)
    else $error("stb without cyc");

  adr_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_req_o.stb && !wb_rsp_i.ack |=> $stable(wb_req_o.adr))
    else $error("wishbone address changed before ack");

endmodule

`default_nettype wire

/* rtl/icache_tag_store.sv */
// tag and valid storage per way, hit compare and victim way choice for refills
`timescale 1ns/1ns
`default_nettype none

module icache_tag_store (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rd_en_i,
  input  icache_pkg::index_t     lookup_idx_i,
  input  icache_pkg::line_addr_t dec_i,
  input  logic                   fill_en_i,
  input  logic                   clr_en_i,
  input  icache_pkg::index_t     clr_idx_i,
  output logic                   hit_o,
  output icache_pkg::way_t       hit_way_o,
  output icache_pkg::way_t       victim_way_o
);

  import icache_pkg::*;

  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
  logic [NUM_WAYS-1:0] vld_rd_q;
  logic [NUM_WAYS-1:0] hit_vec;
  logic [NUM_WAYS-1:0] dup_vec;
  logic rd_q;
  logic all_valid;
  way_t inv_way;
  way_t victim_q;
  logic full_q;
  logic [7:0] lfsr_q;
  logic lfsr_fb;

  //////////////////////////////////////////////////
  // tag arrays, synchronous read
  //////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    tag_t tag_mem [NUM_SETS];
    tag_t tag_rd_q;

    always_ff @(posedge clk_i) begin
      if (fill_en_i && victim_q == way_t'(w)) begin
        tag_mem[dec_i.index] <= dec_i.tag;
      end
      if (rd_en_i) begin
        tag_rd_q <= tag_mem[lookup_idx_i];
      end
    end

    assign hit_vec[w] = vld_rd_q[w] && (tag_rd_q == dec_i.tag);
    // same tag already live in the set being filled
    assign dup_vec[w] = valid_q[dec_i.index][w] && (tag_mem[dec_i.index] == dec_i.tag);
  end

  assign hit_o     = |hit_vec;
  assign all_valid = &vld_rd_q;

  // lowest hitting way and lowest free way
  always_comb begin
    hit_way_o = '0;
    inv_way   = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way_o = way_t'(w);
      end
      if (!vld_rd_q[w]) begin
        inv_way = way_t'(w);
      end
    end
  end

  //////////////////////////////////////////////////
  // valid flags, replacement
  //////////////////////////////////////////////////

  // taps for x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      vld_rd_q <= '0;
      rd_q     <= 1'b0;
      victim_q <= '0;
      full_q   <= 1'b0;
      lfsr_q   <= LFSR_SEED;
    end else begin
      rd_q <= rd_en_i;
      if (rd_en_i) begin
        vld_rd_q <= valid_q[lookup_idx_i];
      end
      // flush sweep wins over a fill
      if (clr_en_i) begin
        valid_q[clr_idx_i] <= '0;
      end else if (fill_en_i) begin
        valid_q[dec_i.index][victim_q] <= 1'b1;
      end
      // victim fixed in the compare cycle, held through the refill
      if (rd_q) begin
        victim_q <= all_valid ? lfsr_q[WAY_WIDTH-1:0] : inv_way;
        full_q   <= all_valid;
      end
      if (fill_en_i && full_q) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
    end
  end

  assign victim_way_o = victim_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rd_q |-> $onehot0(hit_vec))
    else $error("tag hit in more than one way");

  // refills only follow a miss on the same set
  no_dup_fill: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fill_en_i |-> !(|dup_vec))
    else $error("refill would duplicate a valid tag");

endmodule

`default_nettype wire

/* rtl/icache_data_store.sv */
// line storage per way, refill write and selection of the fetched word
`timescale 1ns/1ns
`default_nettype none

module icache_data_store (
  input  logic                   clk_i,
  input  logic                   rd_en_i,
  input  icache_pkg::index_t     lookup_idx_i,
  input  icache_pkg::line_addr_t dec_i,
  input  logic                   fill_en_i,
  input  icache_pkg::way_t       fill_way_i,
  input  icache_pkg::way_t       hit_way_i,
  input  logic                   use_fill_i,
  input  icache_pkg::line_t      fill_line_i,
  output icache_pkg::word_t      word_o
);

  import icache_pkg::*;

  line_t line_rd [NUM_WAYS];
  line_t src_line;

  //////////////////////////////////////////////////
  // line arrays
  //////////////////////////////////////////////////

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    line_t line_mem [NUM_SETS];
    line_t rd_q;

    always_ff @(posedge clk_i) begin
      // refilled line lands in the victim way
      if (fill_en_i && fill_way_i == way_t'(w)) begin
        line_mem[dec_i.index] <= fill_line_i;
      end
      // all ways read in parallel at the accept edge
      if (rd_en_i) begin
        rd_q <= line_mem[lookup_idx_i];
      end
    end

    assign line_rd[w] = rd_q;
  end

  //////////////////////////////////////////////////
  // word select
  //////////////////////////////////////////////////

  // bus line during a refill, else the hitting way
  always_comb begin
    if (use_fill_i) begin
      src_line = fill_line_i;
    end else begin
      src_line = line_rd[hit_way_i];
    end
  end

  assign word_o = src_line[dec_i.offset * WORD_WIDTH +: WORD_WIDTH];

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
// instruction cache top level, fetch port on one side and wishbone memory port on the other
`timescale 1ns/1ns
`default_nettype none

module icache_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   en_i,
  input  logic                   flush_i,
  input  icache_pkg::fetch_req_t fetch_req_i,
  output logic                   fetch_ready_o,
  output icache_pkg::fetch_rsp_t fetch_rsp_o,
  output icache_pkg::wb_req_t    wb_req_o,
  input  icache_pkg::wb_rsp_t    wb_rsp_i
);

  import icache_pkg::*;

  line_addr_t dec;
  index_t lookup_idx;
  index_t clr_idx;
  logic rd_en;
  logic fill_en;
  logic clr_en;
  logic fetch_accept;
  logic valid;
  logic use_fill;
  logic cache_en;
  logic hit;
  way_t hit_way;
  way_t victim_way;
  word_t rsp_word;

  icache_decode u_decode (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_req_i    (fetch_req_i),
    .fetch_accept_i (fetch_accept),
    .cache_en_i     (cache_en),
    .lookup_idx_o   (lookup_idx),
    .dec_o          (dec)
  );

  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_req_i    (fetch_req_i),
    .en_i           (en_i),
    .flush_i        (flush_i),
    .dec_i          (dec),
    .hit_i          (hit),
    .wb_rsp_i       (wb_rsp_i),
    .wb_req_o       (wb_req_o),
    .fetch_ready_o  (fetch_ready_o),
    .fetch_accept_o (fetch_accept),
    .rd_en_o        (rd_en),
    .fill_en_o      (fill_en),
    .clr_en_o       (clr_en),
    .valid_o        (valid),
    .use_fill_o     (use_fill),
    .clr_idx_o      (clr_idx),
    .cache_en_o     (cache_en)
  );

  icache_tag_store u_tag_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_en_i      (rd_en),
    .lookup_idx_i (lookup_idx),
    .dec_i        (dec),
    .fill_en_i    (fill_en),
    .clr_en_i     (clr_en),
    .clr_idx_i    (clr_idx),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way)
  );

  icache_data_store u_data_store (
    .clk_i        (clk_i),
    .rd_en_i      (rd_en),
    .lookup_idx_i (lookup_idx),
    .dec_i        (dec),
    .fill_en_i    (fill_en),
    .fill_way_i   (victim_way),
    .hit_way_i    (hit_way),
    .use_fill_i   (use_fill),
    .fill_line_i  (wb_rsp_i.dat),
    .word_o       (rsp_word)
  );

  // response address is the accepted fetch, word aligned
  assign fetch_rsp_o.valid = valid;
  assign fetch_rsp_o.word  = rsp_word;
  assign fetch_rsp_o.addr  = {dec.tag, dec.index, dec.offset, 2'b00};

endmodule

`default_nettype wire

/* verification/tb_icache_mem.sv */
// wishbone classic slave memory for the cache testbench, one line per beat with random ack delay
`timescale 1ns/1ns
`default_nettype none

module tb_icache_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  icache_pkg::wb_req_t wb_req_i,
  output icache_pkg::wb_rsp_t wb_rsp_o
);

  import icache_pkg::*;

  logic       ack_q;
  logic       busy_q;
  logic [1:0] wait_q;
  line_t      line_dat;

  // contents are a fixed function of the full byte address
  function automatic word_t word_at(input logic [ADDR_WIDTH-1:0] a);
    return {a ^ 16'hC3A5, ~a + 16'h0101};
  endfunction

  always_comb begin
    for (int w = 0; w < LINE_WORDS; w++) begin
      line_dat[w*WORD_WIDTH +: WORD_WIDTH] = word_at(wb_req_i.adr + ADDR_WIDTH'(4 * w));
    end
  end

  // first cycle of a request picks a delay of 0 to 3 further cycles
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      busy_q <= 1'b0;
      wait_q <= '0;
    end else if (ack_q) begin
      ack_q  <= 1'b0;
      busy_q <= 1'b0;
    end else if (wb_req_i.cyc && wb_req_i.stb) begin
      if (!busy_q) begin
        busy_q <= 1'b1;
        wait_q <= 2'($urandom_range(3, 0));
      end else if (wait_q == '0) begin
        ack_q <= 1'b1;
      end else begin
        wait_q <= wait_q - 1'b1;
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = line_dat;

endmodule

`default_nettype wire

/* verification/tb_icache_top.sv */
// testbench top that applies the stimulus table, back to back hits and the replacement test
`timescale 1ns/1ns
`default_nettype none

module tb_icache_top;

  import icache_pkg::*;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  en;
    logic                  flush;
    logic                  exp_wb;
  } stim_t;

  localparam int NUM_ENTRIES = 14;
  // replacement test issues 13 fetches, back to back adds 2
  localparam int CYCLE_LIMIT = (NUM_ENTRIES + 15) * 12 + 300;

  logic       clk_i;
  logic       rst_ni;
  logic       en_i;
  logic       flush_i;
  fetch_req_t fetch_req_i;
  logic       fetch_ready_o;
  fetch_rsp_t fetch_rsp_o;
  wb_req_t    wb_req_o;
  wb_rsp_t    wb_rsp_i;

  int    wb_count;
  logic  cyc_prev;
  int    cycles;
  stim_t table_q [NUM_ENTRIES];

  icache_top u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_rsp_o   (fetch_rsp_o),
    .wb_req_o      (wb_req_o),
    .wb_rsp_i      (wb_rsp_i)
  );

  tb_icache_mem u_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req_o),
    .wb_rsp_o (wb_rsp_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////
  // monitor and timeout
  ////////////////////////////////////////////////////

  // one count per rising cyc
  always @(negedge clk_i) begin
    if (wb_req_o.cyc && !cyc_prev) begin
      wb_count++;
    end
    cyc_prev = wb_req_o.cyc;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // expected memory word, same address function as the model
  function automatic word_t expected_word(input logic [ADDR_WIDTH-1:0] a);
    return {a ^ 16'hC3A5, ~a + 16'h0101};
  endfunction

  task automatic check_rsp(input fetch_rsp_t got, input logic [ADDR_WIDTH-1:0] addr);
    logic [ADDR_WIDTH-1:0] exp_addr;
    exp_addr = {addr[ADDR_WIDTH-1:2], 2'b00};
    if (!got.valid || got.addr !== exp_addr || got.word !== expected_word(exp_addr)) begin
      stop_run($sformatf("MISMATCH at %0t: response addr %h word %h, expected addr %h word %h",
                         $time, got.addr, got.word, exp_addr, expected_word(exp_addr)));
    end
  endtask

  task automatic check_wb(input wb_req_t got, input logic [ADDR_WIDTH-1:0] exp_adr);
    if (!got.stb || got.we || got.adr !== exp_adr) begin
      stop_run($sformatf("MISMATCH at %0t: wishbone stb %b we %b adr %h, expected read at %h",
                         $time, got.stb, got.we, got.adr, exp_adr));
    end
  endtask

  ////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////

  // single fetch, waits for the response and reports whether memory was read
  task automatic fetch_one(input logic [ADDR_WIDTH-1:0] addr, output bit got_wb);
    int start_cnt;
    int waited;
    bit wb_checked;
    logic [ADDR_WIDTH-1:0] line_adr;
    start_cnt  = wb_count;
    waited     = 0;
    wb_checked = 1'b0;
    line_adr   = {addr[ADDR_WIDTH-1:OFFSET_WIDTH+2], {(OFFSET_WIDTH + 2){1'b0}}};
    @(negedge clk_i);
    fetch_req_i.req  = 1'b1;
    fetch_req_i.addr = addr;
    #1;
    while (!fetch_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    // accepted at the edge in between
    @(negedge clk_i);
    fetch_req_i.req = 1'b0;
    #1;
    while (!fetch_rsp_o.valid) begin
      if (wb_req_o.cyc && !wb_checked) begin
        check_wb(wb_req_o, line_adr);
        wb_checked = 1'b1;
      end
      waited++;
      @(negedge clk_i);
      #1;
    end
    check_rsp(fetch_rsp_o, addr);
    got_wb = (wb_count != start_cnt);
    if (wb_count - start_cnt > 1) begin
      stop_run("more than one wishbone read was issued for a single fetch");
    end
    if (got_wb && !wb_checked) begin
      stop_run("wishbone read was not seen before the response");
    end
    if (!got_wb && waited != 0) begin
      stop_run($sformatf("MISMATCH at %0t: hit returned %0d cycles late", $time, waited));
    end
  endtask

  // counts cycles with fetch_ready_o low, starting in the current cycle
  task automatic expect_ready_after(input int exp_low, input string what);
    int low;
    low = 0;
    #1;
    while (!fetch_ready_o) begin
      low++;
      @(negedge clk_i);
      #1;
    end
    if (low != exp_low) begin
      stop_run($sformatf("MISMATCH at %0t: ready low for %0d cycles %s, expected %0d",
                         $time, low, what, exp_low));
    end
  endtask

  // two hits with the second accepted in the cycle that returns the first
  task automatic back_to_back(input logic [ADDR_WIDTH-1:0] a0, input logic [ADDR_WIDTH-1:0] a1);
    int start_cnt;
    start_cnt = wb_count;
    @(negedge clk_i);
    fetch_req_i.req  = 1'b1;
    fetch_req_i.addr = a0;
    #1;
    while (!fetch_ready_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    fetch_req_i.addr = a1;
    #1;
    check_rsp(fetch_rsp_o, a0);
    if (!fetch_ready_o) begin
      stop_run("cache was not ready during a hit cycle");
    end
    @(negedge clk_i);
    fetch_req_i.req = 1'b0;
    #1;
    check_rsp(fetch_rsp_o, a1);
    if (wb_count != start_cnt) begin
      stop_run("back to back hits caused a wishbone read");
    end
  endtask

  // fills one set past its associativity, then looks for the evicted line
  task automatic replacement_test();
    bit got_wb;
    bit found;
    logic [ADDR_WIDTH-1:0] a;
    for (int k = 0; k < 5; k++) begin
      a = {8'h10 + 8'(k), 4'h3, 4'h0};
      fetch_one(a, got_wb);
      if (!got_wb) begin
        stop_run("fill of a new tag did not read memory");
      end
      // after four fills the whole set must hit
      if (k == 3) begin
        for (int j = 0; j < 4; j++) begin
          fetch_one({8'h10 + 8'(j), 4'h3, 4'h0}, got_wb);
          if (got_wb) begin
            stop_run("line of a full set missed before any eviction");
          end
        end
      end
    end
    // stop at the first miss since its refill evicts again
    found = 1'b0;
    for (int j = 0; j < 4 && !found; j++) begin
      fetch_one({8'h10 + 8'(j), 4'h3, 4'h0}, got_wb);
      found = got_wb;
    end
    if (!found) begin
      stop_run("none of the first four lines was evicted by the fifth tag");
    end
  endtask

  ////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////

  initial begin
    bit got_wb;
    void'($urandom(66195));
    // addr, en, flush, memory read expected
    table_q[0]  = '{16'h0100, 1'b1, 1'b0, 1'b1};
    table_q[1]  = '{16'h0104, 1'b1, 1'b0, 1'b0};
    table_q[2]  = '{16'h010C, 1'b1, 1'b0, 1'b0};
    table_q[3]  = '{16'h0109, 1'b1, 1'b0, 1'b0};
    table_q[4]  = '{16'h8100, 1'b1, 1'b0, 1'b1};
    table_q[5]  = '{16'h8104, 1'b1, 1'b0, 1'b1};
    table_q[6]  = '{16'h0210, 1'b1, 1'b0, 1'b1};
    table_q[7]  = '{16'h0214, 1'b1, 1'b0, 1'b0};
    table_q[8]  = '{16'h0104, 1'b0, 1'b0, 1'b1};
    table_q[9]  = '{16'h0104, 1'b0, 1'b0, 1'b1};
    table_q[10] = '{16'h0104, 1'b1, 1'b0, 1'b1};
    table_q[11] = '{16'h0108, 1'b1, 1'b0, 1'b0};
    table_q[12] = '{16'h0100, 1'b1, 1'b1, 1'b1};
    table_q[13] = '{16'h010C, 1'b1, 1'b0, 1'b0};

    wb_count    = 0;
    cyc_prev    = 1'b0;
    cycles      = 0;
    rst_ni      = 1'b0;
    en_i        = 1'b1;
    flush_i     = 1'b0;
    fetch_req_i = '0;

    // sixteen rising edges under reset, released on the falling edge after
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    expect_ready_after(NUM_SETS, "after reset");
    if (wb_count != 0) begin
      stop_run("wishbone cycle seen before the first fetch");
    end

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      @(negedge clk_i);
      if (table_q[i].en && !en_i) begin
        en_i = 1'b1;
        // one idle cycle sees the enable, then the full sweep
        expect_ready_after(NUM_SETS + 1, "after enable");
      end
      en_i = table_q[i].en;
      if (table_q[i].flush) begin
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
      end
      fetch_one(table_q[i].addr, got_wb);
      if (got_wb != table_q[i].exp_wb) begin
        stop_run($sformatf("MISMATCH at %0t: entry %0d memory read %b, expected %b",
                           $time, i, got_wb, table_q[i].exp_wb));
      end
    end

    back_to_back(16'h0104, 16'h0108);
    replacement_test();

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* icache_top.f */
rtl/icache_pkg.sv
rtl/icache_decode.sv
rtl/icache_ctrl.sv
rtl/icache_tag_store.sv
rtl/icache_data_store.sv
rtl/icache_top.sv
verification/tb_icache_mem.sv
verification/tb_icache_top.sv
